//--- run.sh
#!/bin/sh
# Build and run the scalar integer unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module scalar_integer_unit_tb \
  -o scalar_integer_unit_sim

# The log decides pass or fail, not the simulator exit code
obj_dir/scalar_integer_unit_sim | tee sim.log

grep -qx '\*\* PASS \*\*' sim.log
echo "Simulation passed"

//--- sources.f
+incdir+src
src/scalar_data_pkg.sv
src/scalar_ctrl_pkg.sv
src/scalar_integer_divider.sv
src/scalar_integer_multiplier.sv
src/scalar_integer_unit.sv
verif/scalar_integer_unit_assert.sv
verif/scalar_integer_unit_tb.sv

//--- src/scalar_consts.svh
////////////////////
// Scalar integer unit constants
// Operand width and the width of the
// iteration counter of both engines
////////////////////

`ifndef SCALAR_CONSTS_SVH
`define SCALAR_CONSTS_SVH

// Operand width in bits
`define SCALAR_DATA_SIZE 32

// Iteration counter width
// Holds 0 to SCALAR_DATA_SIZE-1 with one spare bit
`define SCALAR_COUNT_SIZE ($clog2(`SCALAR_DATA_SIZE) + 1)

`endif

//--- src/scalar_ctrl_pkg.sv
////////////////////
// Scalar integer unit control types
// Operation codes, engine states and the
// command and result words
////////////////////

`include "scalar_consts.svh"

package scalar_ctrl_pkg;
  import scalar_data_pkg::*;

  // Operation select
  typedef enum logic {
    OP_DIV = 1'b0,
    OP_MUL = 1'b1
  } op_t;

  // Shared by both engines
  typedef enum logic [1:0] {
    ENGINE_IDLE = 2'd0,
    ENGINE_RUN  = 2'd1,
    ENGINE_DONE = 2'd2
  } engine_state_t;

  // Command word with op in the top bit
  typedef struct packed {
    op_t   op;
    data_t a;
    data_t b;
  } scalar_cmd_t;

  // Quotient/remainder or low/high product
  typedef struct packed {
    data_t hi;
    data_t lo;
  } scalar_result_t;

endpackage

//--- src/scalar_data_pkg.sv
////////////////////
// Scalar integer unit data types
// Vector widths with a meaning in the datapath
////////////////////

`include "scalar_consts.svh"

package scalar_data_pkg;

  // One operand or one result word
  typedef logic [`SCALAR_DATA_SIZE-1:0] data_t;

  // Partial remainder or partial sum with carry
  typedef logic [`SCALAR_DATA_SIZE:0] wide_t;

  // Iteration counter
  typedef logic [`SCALAR_COUNT_SIZE-1:0] count_t;

endpackage

//--- src/scalar_integer_divider.sv
////////////////////
// Scalar integer divider
// Restoring division with one quotient bit per cycle
// Returns quotient in lo and remainder in hi
// Divide by zero yields all ones and the dividend
////////////////////

`include "scalar_consts.svh"

module scalar_integer_divider (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            START,
  input  scalar_data_pkg::data_t          DATA_A_IN,
  input  scalar_data_pkg::data_t          DATA_B_IN,
  output logic                            READY,
  output scalar_ctrl_pkg::scalar_result_t RESULT
);
  import scalar_data_pkg::*;
  import scalar_ctrl_pkg::*;

  ////////////////////
  // Signals

  engine_state_t state;
  count_t        count;

  // Dividend shifts out at the top while quotient bits enter at the bottom
  data_t quot;
  data_t divisor;
  wide_t rem;

  // One iteration
  wide_t shifted;
  wide_t trial;
  logic  q_bit;
  wide_t rem_next;
  data_t quot_next;

  ////////////////////
  // Iteration logic

  always_comb begin
    // Bring down the next dividend bit
    shifted   = {rem[`SCALAR_DATA_SIZE-1:0], quot[`SCALAR_DATA_SIZE-1]};
    trial     = shifted - {1'b0, divisor};
    // Zero divisor always passes this compare
    q_bit     = (shifted >= {1'b0, divisor});
    rem_next  = q_bit ? trial : shifted;
    quot_next = {quot[`SCALAR_DATA_SIZE-2:0], q_bit};
  end

  // Datapath registers
  always_ff @(posedge CLK) begin
    if (state == ENGINE_IDLE && START) begin
      quot    <= DATA_A_IN;
      divisor <= DATA_B_IN;
      rem     <= '0;
    end else if (state == ENGINE_RUN) begin
      quot <= quot_next;
      rem  <= rem_next;
    end
  end

  ////////////////////
  // Control FSM

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= ENGINE_IDLE;
      count  <= '0;
      READY  <= 1'b0;
      RESULT <= '0;
    end else begin
      // Single cycle pulse by default
      READY <= 1'b0;
      case (state)
        ENGINE_IDLE: begin
          if (START) begin
            count <= count_t'(`SCALAR_DATA_SIZE - 1);
            state <= ENGINE_RUN;
          end
        end
        ENGINE_RUN: begin
          count <= count - count_t'(1);
          // Last iteration publishes the result
          if (count == '0) begin
            RESULT.lo <= quot_next;
            RESULT.hi <= rem_next[`SCALAR_DATA_SIZE-1:0];
            READY     <= 1'b1;
            state     <= ENGINE_DONE;
          end
        end
        ENGINE_DONE: state <= ENGINE_IDLE;
        default:     state <= ENGINE_IDLE;
      endcase
    end
  end

endmodule

//--- src/scalar_integer_multiplier.sv
////////////////////
// Scalar integer multiplier
// Shift and add over one multiplier bit per cycle
// Returns the double width product as lo and hi
////////////////////

`include "scalar_consts.svh"

module scalar_integer_multiplier (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            START,
  input  scalar_data_pkg::data_t          DATA_A_IN,
  input  scalar_data_pkg::data_t          DATA_B_IN,
  output logic                            READY,
  output scalar_ctrl_pkg::scalar_result_t RESULT
);
  import scalar_data_pkg::*;
  import scalar_ctrl_pkg::*;

  ////////////////////
  // Signals

  engine_state_t state;
  count_t        count;

  data_t mcand;
  // Product register with multiplier bits consumed from the bottom
  data_t prod_hi;
  data_t prod_lo;

  // Partial sum with carry
  wide_t sum;

  ////////////////////
  // Iteration logic

  // Add multiplicand when the current multiplier bit is set
  assign sum = {1'b0, prod_hi} + (prod_lo[0] ? {1'b0, mcand} : '0);

  always_ff @(posedge CLK) begin
    if (state == ENGINE_IDLE && START) begin
      mcand   <= DATA_A_IN;
      prod_hi <= '0;
      prod_lo <= DATA_B_IN;
    end else if (state == ENGINE_RUN) begin
      // Whole product shifts right by one
      prod_hi <= sum[`SCALAR_DATA_SIZE:1];
      prod_lo <= {sum[0], prod_lo[`SCALAR_DATA_SIZE-1:1]};
    end
  end

  ////////////////////
  // Control FSM

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= ENGINE_IDLE;
      count  <= '0;
      READY  <= 1'b0;
      RESULT <= '0;
    end else begin
      READY <= 1'b0;
      case (state)
        ENGINE_IDLE: begin
          if (START) begin
            count <= count_t'(`SCALAR_DATA_SIZE - 1);
            state <= ENGINE_RUN;
          end
        end
        ENGINE_RUN: begin
          count <= count - count_t'(1);
          if (count == '0) begin
            // Same shift as the datapath for the final bit
            RESULT.hi <= sum[`SCALAR_DATA_SIZE:1];
            RESULT.lo <= {sum[0], prod_lo[`SCALAR_DATA_SIZE-1:1]};
            READY     <= 1'b1;
            state     <= ENGINE_DONE;
          end
        end
        ENGINE_DONE: state <= ENGINE_IDLE;
        default:     state <= ENGINE_IDLE;
      endcase
    end
  end

endmodule

//--- src/scalar_integer_unit.sv
////////////////////
// Scalar integer unit
// Accepts one command at a time and runs it on
// the divider or the multiplier engine
// Result is registered and held until the next READY
////////////////////

`include "scalar_consts.svh"

module scalar_integer_unit (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            START,
  input  scalar_ctrl_pkg::scalar_cmd_t    CMD,
  output logic                            BUSY,
  output logic                            READY,
  output scalar_ctrl_pkg::scalar_result_t RESULT
);
  import scalar_ctrl_pkg::*;

  ////////////////////
  // Command steering

  // Commands during BUSY are dropped
  logic accept;
  logic div_start;
  logic mul_start;

  logic           div_ready;
  logic           mul_ready;
  scalar_result_t div_result;
  scalar_result_t mul_result;

  assign accept    = START & ~BUSY;
  assign div_start = accept & (CMD.op == OP_DIV);
  assign mul_start = accept & (CMD.op == OP_MUL);

  ////////////////////
  // Engines

  scalar_integer_divider div_i (
    .CLK       (CLK),
    .RST       (RST),
    .START     (div_start),
    .DATA_A_IN (CMD.a),
    .DATA_B_IN (CMD.b),
    .READY     (div_ready),
    .RESULT    (div_result)
  );

  scalar_integer_multiplier mul_i (
    .CLK       (CLK),
    .RST       (RST),
    .START     (mul_start),
    .DATA_A_IN (CMD.a),
    .DATA_B_IN (CMD.b),
    .READY     (mul_ready),
    .RESULT    (mul_result)
  );

  ////////////////////
  // Busy and result register

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      BUSY   <= 1'b0;
      READY  <= 1'b0;
      RESULT <= '0;
    end else begin
      READY <= 1'b0;
      if (accept) begin
        BUSY <= 1'b1;
      end
      // Only the started engine can finish
      if (div_ready) begin
        RESULT <= div_result;
        READY  <= 1'b1;
        BUSY   <= 1'b0;
      end else if (mul_ready) begin
        RESULT <= mul_result;
        READY  <= 1'b1;
        BUSY   <= 1'b0;
      end
    end
  end

endmodule

//--- verif/scalar_integer_unit_assert.sv
////////////////////
// Scalar integer unit protocol checks
// READY pulse width, BUSY against READY
// and quiet outputs during reset
////////////////////

module scalar_integer_unit_assert (
  input logic CLK,
  input logic RST,
  input logic BUSY,
  input logic READY
);

  // Result strobe is a single cycle
  ready_pulse_a : assert property (
    @(posedge CLK) disable iff (RST) READY |=> !READY
  ) else $error("READY held high for more than one cycle");

  // BUSY drops in the READY cycle
  ready_not_busy_a : assert property (
    @(posedge CLK) disable iff (RST) READY |-> !BUSY
  ) else $error("BUSY high while READY is high");

  // Nothing moves while reset is held
  reset_quiet_a : assert property (
    @(posedge CLK) RST |-> (!READY && !BUSY)
  ) else $error("READY or BUSY high during reset");

endmodule

//--- verif/scalar_integer_unit_tb.sv
////////////////////
// Scalar integer unit testbench
// Random division and multiplication commands
// against a reference model, with reset, latency
// and dropped START checks
////////////////////

`include "scalar_consts.svh"

module scalar_integer_unit_tb;
  import scalar_data_pkg::*;
  import scalar_ctrl_pkg::*;

  // Clock cycles from START sample to visible READY
  localparam int LATENCY     = `SCALAR_DATA_SIZE + 2;
  localparam int CYCLE_LIMIT = 80 * 40 + 100;

  logic           CLK;
  logic           RST;
  logic           START;
  scalar_cmd_t    CMD;
  logic           BUSY;
  logic           READY;
  scalar_result_t RESULT;

  data_t lcg_state;
  int    cycle   = 0;
  int    errors  = 0;
  int    tests   = 0;
  int    issued  = 0;
  int    checked = 0;

  // Outstanding commands with the oldest first
  scalar_result_t exp_q[$];
  string          name_q[$];
  int             start_q[$];

  scalar_integer_unit scalar_integer_unit_i (
    .CLK    (CLK),
    .RST    (RST),
    .START  (START),
    .CMD    (CMD),
    .BUSY   (BUSY),
    .READY  (READY),
    .RESULT (RESULT)
  );

  bind scalar_integer_unit scalar_integer_unit_assert assert_i (
    .CLK   (CLK),
    .RST   (RST),
    .BUSY  (BUSY),
    .READY (READY)
  );

  ////////////////////
  // Clock and timeout

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Simulation timed out after %0d cycles", cycle);
      $display("** FAIL **");
      $finish;
    end
  end

  ////////////////////
  // Models and checks

  // Upper halves of two LCG steps
  function automatic data_t rand_word();
    data_t first;
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    first     = lcg_state;
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {first[31:16], lcg_state[31:16]};
  endfunction

  function automatic scalar_result_t ref_result(op_t op, data_t a, data_t b);
    scalar_result_t r;
    logic [2*`SCALAR_DATA_SIZE-1:0] prod;
    prod = {{`SCALAR_DATA_SIZE{1'b0}}, a} * {{`SCALAR_DATA_SIZE{1'b0}}, b};
    if (op == OP_MUL) begin
      r.lo = prod[`SCALAR_DATA_SIZE-1:0];
      r.hi = prod[2*`SCALAR_DATA_SIZE-1:`SCALAR_DATA_SIZE];
    end else if (b == '0) begin
      // All ones and the dividend left over on divide by zero
      r.lo = '1;
      r.hi = a;
    end else begin
      r.lo = a / b;
      r.hi = a % b;
    end
    return r;
  endfunction

  task automatic check_data(string name, string field, data_t expected, data_t actual);
    if (actual !== expected) begin
      $display("FAILED %s %s expected %h actual %h", name, field, expected, actual);
      errors++;
    end
  endtask

  task automatic check_flag(string name, string field, logic expected, logic actual);
    if (actual !== expected) begin
      $display("FAILED %s %s expected %b actual %b", name, field, expected, actual);
      errors++;
    end
  endtask

  task automatic check_ready(string name, int start_cycle);
    if (cycle - start_cycle != LATENCY) begin
      $display("FAILED %s latency expected %0d actual %0d", name, LATENCY,
               cycle - start_cycle);
      errors++;
    end
  endtask

  task automatic report_test(string name, int errors_before);
    tests++;
    $display("%s %s", name, (errors == errors_before) ? "ok" : "failed");
  endtask

  ////////////////////
  // Command driver

  task automatic issue_cmd(string name, op_t op, data_t a, data_t b);
    @(negedge CLK);
    while (BUSY) @(negedge CLK);
    START  = 1'b1;
    CMD.op = op;
    CMD.a  = a;
    CMD.b  = b;
    exp_q.push_back(ref_result(op, a, b));
    name_q.push_back(name);
    start_q.push_back(cycle);
    issued++;
    @(negedge CLK);
    START = 1'b0;
  endtask

  task automatic run_cmd(string name, op_t op, data_t a, data_t b);
    issue_cmd(name, op, a, b);
    wait (checked == issued);
  endtask

  ////////////////////
  // Result compare

  initial begin : compare
    scalar_result_t expected;
    string          name;
    int             start_cycle;
    int             errors_before;
    forever begin
      @(negedge CLK);
      if (READY) begin
        if (exp_q.size() == 0) begin
          $display("READY pulsed at cycle %0d with no command outstanding", cycle);
          errors++;
        end else begin
          expected      = exp_q.pop_front();
          name          = name_q.pop_front();
          start_cycle   = start_q.pop_front();
          errors_before = errors;
          check_data(name, "lo", expected.lo, RESULT.lo);
          check_data(name, "hi", expected.hi, RESULT.hi);
          check_flag(name, "busy", 1'b0, BUSY);
          check_ready(name, start_cycle);
          report_test(name, errors_before);
          checked++;
        end
      end
    end
  end

  ////////////////////
  // Test sequence

  initial begin : stimulus
    data_t a;
    data_t b;
    int    errors_before;
    lcg_state = 32'd52800;
    RST   = 1'b1;
    START = 1'b0;
    CMD   = '0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Reset values
    errors_before = errors;
    check_flag("reset", "busy", 1'b0, BUSY);
    check_flag("reset", "ready", 1'b0, READY);
    check_data("reset", "lo", '0, RESULT.lo);
    check_data("reset", "hi", '0, RESULT.hi);
    report_test("reset", errors_before);

    // Nonzero divisors of random magnitude
    for (int i = 0; i < 40; i++) begin
      a = rand_word();
      b = rand_word();
      b = b >> (rand_word() % 32);
      if (b == '0) b = data_t'(1);
      run_cmd($sformatf("div_%0d", i), OP_DIV, a, b);
    end

    for (int i = 0; i < 4; i++) begin
      a = (i == 0) ? data_t'(0) : rand_word();
      run_cmd($sformatf("div_zero_%0d", i), OP_DIV, a, '0);
    end

    // First case is all ones times all ones
    for (int i = 0; i < 30; i++) begin
      a = (i == 0) ? '1 : rand_word();
      b = (i == 0) ? '1 : rand_word();
      run_cmd($sformatf("mul_%0d", i), OP_MUL, a, b);
    end

    // Second START while busy must be dropped
    a = rand_word();
    b = rand_word() | data_t'(1);
    issue_cmd("busy_drop", OP_DIV, a, b);
    repeat (5) @(negedge CLK);
    START  = 1'b1;
    CMD.op = OP_MUL;
    CMD.a  = ~a;
    CMD.b  = ~b;
    @(negedge CLK);
    START = 1'b0;
    wait (checked == issued);
    errors_before = errors;
    repeat (2 * LATENCY) @(negedge CLK);
    report_test("busy_no_second_ready", errors_before);

    $display("Tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
